/* hdl/muldiv_pkg.sv */
// Multiply/divide shared types
`default_nettype none

package muldiv_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int xlen  = 32;  // Operand and result width
  localparam int tag_w = 5;   // Request tag width
  localparam int fn_w  = 4;   // Function code width

  // Iteration counts
  localparam int mul_steps = 4;   // Eight multiplier bits per step
  localparam int div_steps = 33;  // Counter runs 0 to 32, first step only probes for zero

  // --------------------
  // Function codes
  // --------------------
  typedef enum logic [fn_w-1:0] {
    fn_mul    = 4'd0,
    fn_mulh   = 4'd1,
    fn_mulhsu = 4'd2,
    fn_mulhu  = 4'd3,
    fn_div    = 4'd4,
    fn_divu   = 4'd5,
    fn_rem    = 4'd6,
    fn_remu   = 4'd7
  } fn_t;

  // --------------------
  // Payloads
  // --------------------
  typedef struct packed {
    fn_t              fn;   // Operation
    logic [xlen-1:0]  in1;  // rs1 value, multiplier or dividend
    logic [xlen-1:0]  in2;  // rs2 value, multiplicand or divisor
    logic [tag_w-1:0] tag;  // Returned with the result
  } muldiv_req_t;

  typedef struct packed {
    logic [xlen-1:0]  data;
    logic [tag_w-1:0] tag;
  } muldiv_resp_t;

  // Decoded operation, built from fn and operand signs
  typedef struct packed {
    logic is_mul;      // Multiply, else divide
    logic is_hi;       // High product half, or remainder
    logic lhs_signed;
    logic rhs_signed;
    logic lhs_neg;     // Sign of in1 when read as signed
    logic rhs_neg;     // Sign of in2 when read as signed
  } op_decode_t;

endpackage

`default_nettype wire

/* hdl/muldiv_decode.sv */
// Function code decoder
`timescale 1ns/100ps
`default_nettype none

module muldiv_decode (
  input  muldiv_pkg::muldiv_req_t req,
  output muldiv_pkg::op_decode_t  dec
);

  logic [muldiv_pkg::fn_w-1:0] fn;  // Raw code bits for the mask terms
  logic is_mul;
  logic is_hi;
  logic lhs_signed;
  logic rhs_signed;

  assign fn = req.fn;

  // --------------------
  // Mask decode
  // --------------------
  // Bit 2 clear selects the multiplier
  assign is_mul = (fn & 4'h4) == 4'h0;

  // MULH, MULHSU, MULHU, REM, REMU
  assign is_hi = ((fn & 4'h5) == 4'h1) | ((fn & 4'h2) == 4'h2);

  // Signed rs1 for MUL, MULH, MULHSU, DIV, REM
  assign lhs_signed = ((fn & 4'h6) == 4'h0) | ((fn & 4'h1) == 4'h0);

  // Signed rs2 for MUL, MULH, DIV, REM
  assign rhs_signed = ((fn & 4'h6) == 4'h0) | ((fn & 4'h5) == 4'h4);

  // --------------------
  // Output
  // --------------------
  always_comb begin
    dec            = '0;
    dec.is_mul     = is_mul;
    dec.is_hi      = is_hi;
    dec.lhs_signed = lhs_signed;
    dec.rhs_signed = rhs_signed;
    dec.lhs_neg    = lhs_signed & req.in1[muldiv_pkg::xlen-1];  // Sign only counts if signed
    dec.rhs_neg    = rhs_signed & req.in2[muldiv_pkg::xlen-1];
  end

endmodule

`default_nettype wire

/* hdl/muldiv_mul_step.sv */
// Radix-256 multiply step
`timescale 1ns/100ps
`default_nettype none

module muldiv_mul_step (
  input  logic [2*muldiv_pkg::xlen+1:0] work,          // {accum, byte sign, multiplier}
  input  logic [muldiv_pkg::xlen:0]     multiplicand,  // Sign-extended rs2
  output logic [2*muldiv_pkg::xlen+1:0] work_next
);

  logic        [muldiv_pkg::xlen:0]   accum;      // Upper 33 bits of running product
  logic        [muldiv_pkg::xlen-1:0] mplier;     // Remaining multiplier, low product bits
  logic signed [8:0]                  mbyte;      // Low multiplier byte plus sign bit
  logic signed [muldiv_pkg::xlen+9:0] product;    // 9 x 33 partial product
  logic signed [muldiv_pkg::xlen+9:0] accum_ext;
  logic signed [muldiv_pkg::xlen+9:0] sum;

  // --------------------
  // Unpack working register
  // --------------------
  assign accum  = work[2*muldiv_pkg::xlen+1:muldiv_pkg::xlen+1];
  assign mplier = work[muldiv_pkg::xlen-1:0];

  // Bit 32 is set by the controller only on the last byte of a signed multiplier
  assign mbyte = {work[muldiv_pkg::xlen], mplier[7:0]};

  // --------------------
  // Multiply and accumulate
  // --------------------
  assign product   = mbyte * $signed(multiplicand);
  assign accum_ext = {{9{accum[muldiv_pkg::xlen]}}, accum};  // Sign extend to 42 bits
  assign sum       = product + accum_ext;

  // Low sum byte drops into product bits, multiplier moves down a byte
  assign work_next = {
    sum[muldiv_pkg::xlen+8:8],          // New accumulator
    1'b0,                               // Byte sign, re-driven by controller
    sum[7:0],                           // Finished product byte
    mplier[muldiv_pkg::xlen-1:8]        // Next multiplier bytes
  };

endmodule

`default_nettype wire

/* hdl/muldiv_div_step.sv */
// Restoring divide step
`timescale 1ns/100ps
`default_nettype none

module muldiv_div_step (
  input  logic [2*muldiv_pkg::xlen+1:0] work,     // {0, partial remainder, dividend/quotient}
  input  logic [muldiv_pkg::xlen:0]     divisor,  // 33-bit, non-negative while dividing
  output logic [2*muldiv_pkg::xlen+1:0] work_next,
  output logic [muldiv_pkg::xlen:0]     diff,     // Trial subtract result
  output logic                          below     // Trial difference went negative
);

  logic [muldiv_pkg::xlen-1:0] rem_keep;  // Remainder after restore decision

  // --------------------
  // Trial subtract
  // --------------------
  assign diff  = work[2*muldiv_pkg::xlen:muldiv_pkg::xlen] - divisor;
  assign below = diff[muldiv_pkg::xlen];  // Sign of the 33-bit difference

  // Restore on negative, otherwise take the difference
  assign rem_keep = below ? work[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen]
                          : diff[muldiv_pkg::xlen-1:0];

  // --------------------
  // Shift
  // --------------------
  // Quotient bit enters at the bottom as the dividend shifts up
  assign work_next = {
    1'b0,
    rem_keep,
    work[muldiv_pkg::xlen-1:0],
    ~below                                // Quotient bit
  };

endmodule

`default_nettype wire

/* hdl/muldiv_ctrl.sv */
// Multiply/divide sequencer
`timescale 1ns/100ps
`default_nettype none

module muldiv_ctrl (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          req_valid,
  output logic                          req_ready,
  input  muldiv_pkg::muldiv_req_t       req,
  input  muldiv_pkg::op_decode_t        dec,
  input  logic                          kill,
  output logic                          resp_valid,
  input  logic                          resp_ready,
  output muldiv_pkg::muldiv_resp_t      resp,
  output logic [2*muldiv_pkg::xlen+1:0] work,
  output logic [muldiv_pkg::xlen:0]     divisor,
  input  logic [2*muldiv_pkg::xlen+1:0] mul_next,
  input  logic [2*muldiv_pkg::xlen+1:0] div_next,
  input  logic [muldiv_pkg::xlen:0]     div_diff,
  input  logic                          div_below
);

  typedef enum logic [2:0] {
    st_idle,
    st_prep,      // Take magnitudes of signed operands
    st_mul,
    st_div,
    st_neg,       // Two's complement the result
    st_resp_mul,
    st_resp_div
  } state_t;

  state_t                         state;
  logic [muldiv_pkg::tag_w-1:0]   tag_q;
  logic [5:0]                     count;      // Step counter, 0 to 32
  logic                           neg_q;      // Result needs negation
  logic                           hi_q;       // High half or remainder wanted
  logic [2*muldiv_pkg::xlen+1:0]  work_q;
  logic [muldiv_pkg::xlen:0]      divisor_q;
  logic [muldiv_pkg::xlen-1:0]    result;
  logic [muldiv_pkg::xlen-1:0]    neg_result;
  logic                           req_fire;
  logic                           resp_fire;
  logic                           last_sign;  // Sign bit for last multiplier byte

  // --------------------
  // Handshake
  // --------------------
  assign req_ready  = state == st_idle;
  assign resp_valid = (state == st_resp_mul) | (state == st_resp_div);
  assign req_fire   = req_valid & req_ready;
  assign resp_fire  = resp_valid & resp_ready;

  // --------------------
  // Result select
  // --------------------
  assign result     = hi_q ? work_q[2*muldiv_pkg::xlen:muldiv_pkg::xlen+1]
                           : work_q[muldiv_pkg::xlen-1:0];
  assign neg_result = ~result + 1'b1;

  assign resp.data = result;
  assign resp.tag  = tag_q;

  // Multiplier sign rides in bit 32, only on the final byte
  assign last_sign = neg_q & (count == muldiv_pkg::mul_steps - 1);
  assign work      = (state == st_mul)
                   ? {work_q[2*muldiv_pkg::xlen+1:muldiv_pkg::xlen+1], last_sign,
                      work_q[muldiv_pkg::xlen-1:0]}
                   : work_q;
  assign divisor   = divisor_q;

  // --------------------
  // Sequencer
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= st_idle;
      tag_q  <= '0;
      count  <= '0;
      neg_q  <= 1'b0;
      hi_q   <= 1'b0;
      work_q <= '0;
    end else if (kill) begin
      state <= st_idle;  // Drop the operation, no response
    end else begin
      case (state)
        st_idle: begin
          if (req_fire) begin
            tag_q  <= req.tag;
            count  <= '0;
            hi_q   <= dec.is_hi;
            work_q <= {{(muldiv_pkg::xlen+2){1'b0}}, req.in1};
            // Remainder follows the dividend, quotient the sign product
            neg_q  <= dec.is_hi ? dec.lhs_neg : (dec.lhs_neg ^ dec.rhs_neg);
            if (dec.is_mul)
              state <= st_mul;
            else if (dec.lhs_neg | dec.rhs_neg)
              state <= st_prep;
            else
              state <= st_div;
          end
        end
        st_prep: begin
          if (work_q[muldiv_pkg::xlen-1])  // Negative dividend
            work_q <= {{(muldiv_pkg::xlen+2){1'b0}}, ~work_q[muldiv_pkg::xlen-1:0] + 1'b1};
          state <= st_div;
        end
        st_mul: begin
          work_q <= mul_next;
          count  <= count + 1'b1;
          if (count == muldiv_pkg::mul_steps - 1)
            state <= st_resp_mul;
        end
        st_div: begin
          work_q <= div_next;
          count  <= count + 1'b1;
          // First step subtracts from zero, so no borrow means divisor is zero
          if (count == 0 && !div_below && !hi_q)
            neg_q <= 1'b0;  // Quotient stays all ones
          if (count == muldiv_pkg::div_steps - 1)
            state <= neg_q ? st_neg : st_resp_div;
        end
        st_neg: begin
          if (hi_q)
            work_q[2*muldiv_pkg::xlen:muldiv_pkg::xlen+1] <= neg_result;
          else
            work_q[muldiv_pkg::xlen-1:0] <= neg_result;
          state <= st_resp_div;
        end
        st_resp_mul, st_resp_div: begin
          if (resp_fire)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Divisor load, then magnitude in prep
  always_ff @(posedge clock) begin
    if (req_fire)
      divisor_q <= {dec.rhs_neg, req.in2};
    else if (state == st_prep && divisor_q[muldiv_pkg::xlen])
      divisor_q <= div_diff;  // Zero minus divisor
  end

endmodule

`default_nettype wire

/* hdl/muldiv_unit.sv */
// Multiply/divide unit top
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  muldiv_pkg::muldiv_req_t  req,
  input  logic                     kill,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output muldiv_pkg::muldiv_resp_t resp
);

  // --------------------
  // Internal wiring
  // --------------------
  muldiv_pkg::op_decode_t        dec;
  logic [2*muldiv_pkg::xlen+1:0] work;       // Controller working register
  logic [muldiv_pkg::xlen:0]     divisor;    // Also the multiplicand
  logic [2*muldiv_pkg::xlen+1:0] mul_next;
  logic [2*muldiv_pkg::xlen+1:0] div_next;
  logic [muldiv_pkg::xlen:0]     div_diff;
  logic                          div_below;

  muldiv_decode muldiv_decode_i (
    .req (req),
    .dec (dec)
  );

  muldiv_ctrl muldiv_ctrl_i (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .dec        (dec),
    .kill       (kill),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp),
    .work       (work),
    .divisor    (divisor),
    .mul_next   (mul_next),
    .div_next   (div_next),
    .div_diff   (div_diff),
    .div_below  (div_below)
  );

  muldiv_mul_step muldiv_mul_step_i (
    .work         (work),
    .multiplicand (divisor),
    .work_next    (mul_next)
  );

  muldiv_div_step muldiv_div_step_i (
    .work      (work),
    .divisor   (divisor),
    .work_next (div_next),
    .diff      (div_diff),
    .below     (div_below)
  );

endmodule

`default_nettype wire

/* verification/muldiv_ref_model.svh */
// RISC-V M-extension reference
`ifndef muldiv_ref_model_svh
`define muldiv_ref_model_svh

// Full 64-bit product with each operand read signed or unsigned
function automatic logic [63:0] wide_product(input logic [31:0] a, input logic [31:0] b,
                                             input logic a_signed, input logic b_signed);
  logic [63:0] wa;
  logic [63:0] wb;
  wa = a_signed ? {{32{a[31]}}, a} : {32'b0, a};
  wb = b_signed ? {{32{b[31]}}, b} : {32'b0, b};
  return wa * wb;  // Product modulo 2**64 of the extended values
endfunction

// Result of one function code as the specification defines it
function automatic logic [31:0] riscv_result(input muldiv_pkg::fn_t fn,
                                             input logic [31:0] a, input logic [31:0] b);
  logic [63:0]        prod;
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  logic               overflow;  // Most negative divided by minus one
  sa       = a;
  sb       = b;
  overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  prod     = wide_product(a, b, fn == muldiv_pkg::fn_mulh || fn == muldiv_pkg::fn_mulhsu,
                          fn == muldiv_pkg::fn_mulh);
  case (fn)
    muldiv_pkg::fn_mul:    return prod[31:0];
    muldiv_pkg::fn_mulh,
    muldiv_pkg::fn_mulhsu,
    muldiv_pkg::fn_mulhu:  return prod[63:32];
    muldiv_pkg::fn_div: begin
      if (b == 32'h0) return 32'hffff_ffff;  // Quotient of zero divisor
      else if (overflow) return a;
      else return sa / sb;                  // Truncates toward zero
    end
    muldiv_pkg::fn_divu: begin
      if (b == 32'h0) return 32'hffff_ffff;
      else return a / b;
    end
    muldiv_pkg::fn_rem: begin
      if (b == 32'h0) return a;             // Remainder is the dividend
      else if (overflow) return 32'h0;
      else return sa % sb;                  // Sign follows the dividend
    end
    muldiv_pkg::fn_remu: begin
      if (b == 32'h0) return a;
      else return a % b;
    end
    default: return 32'h0;
  endcase
endfunction

`endif

/* verification/muldiv_tb.sv */
// Multiply/divide unit testbench
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb;

  typedef struct packed {
    muldiv_pkg::muldiv_req_t req;
    logic [31:0]             expected;  // Reference result
  } row_t;

  logic                     clock;
  logic                     reset;
  logic                     req_valid;
  logic                     req_ready;
  muldiv_pkg::muldiv_req_t  req;
  logic                     kill;
  logic                     resp_valid;
  logic                     resp_ready;
  muldiv_pkg::muldiv_resp_t resp;

  row_t        rows[$];     // Stimulus table
  logic [31:0] rand_state;  // LCG state
  int          errors;
  int          checks;
  logic        table_done;

  `include "muldiv_ref_model.svh"

  muldiv_unit muldiv_unit_i (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .kill       (kill),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;  // 4 ns period
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] lcg_next();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic row_t make_row(input muldiv_pkg::fn_t fn, input logic [31:0] a,
                                    input logic [31:0] b, input logic [4:0] tag);
    row_t row;
    row.req.fn   = fn;
    row.req.in1  = a;
    row.req.in2  = b;
    row.req.tag  = tag;
    row.expected = riscv_result(fn, a, b);
    return row;
  endfunction

  task automatic add_row(input muldiv_pkg::fn_t fn, input logic [31:0] a, input logic [31:0] b);
    int n;
    n = rows.size();
    rows.push_back(make_row(fn, a, b, n[4:0]));  // Tag from row index
  endtask

  // Hold the request until the DUT takes it and return one cycle later
  task automatic send_request(input muldiv_pkg::muldiv_req_t r);
    int wait_cycles;
    @(negedge clock);
    req_valid   = 1'b1;
    req         = r;
    wait_cycles = 0;
    while (!req_ready && wait_cycles < 100) begin
      @(negedge clock);
      wait_cycles++;
    end
    if (!req_ready) begin
      errors++;
      $display("Request with tag %0d was never accepted", r.tag);
    end
    @(negedge clock);  // Taken on the edge just passed
    req_valid = 1'b0;
  endtask

  task automatic run_row(input row_t row);
    muldiv_pkg::muldiv_resp_t held;
    logic [31:0]              r;
    int                       lat;
    int                       stall;
    send_request(row.req);
    lat = 0;
    while (!resp_valid && lat < 200) begin
      check_value("req_ready", req_ready, 0);  // Busy while in flight
      @(negedge clock);
      lat++;
    end
    if (!resp_valid) begin
      errors++;
      $display("No response arrived for tag %0d", row.req.tag);
    end else begin
      if (row.req.fn < muldiv_pkg::fn_div)
        check_value("resp_valid latency", lat, 4);
      check_value("resp.data", resp.data, row.expected);
      check_value("resp.tag", resp.tag, row.req.tag);
      held  = resp;
      r     = lcg_next();
      stall = r[17:16];  // 0 to 3 cycles of back-pressure
      repeat (stall) begin
        @(negedge clock);
        check_value("resp_valid", resp_valid, 1);
        check_value("resp", resp, held);
        check_value("req_ready", req_ready, 0);
      end
      resp_ready = 1'b1;
      @(negedge clock);
      resp_ready = 1'b0;
      check_value("resp_valid", resp_valid, 0);
      check_value("req_ready", req_ready, 1);
    end
  endtask

  // Abandon a divide part way and expect no response
  task automatic kill_divide(input row_t row);
    send_request(row.req);
    repeat (10) begin
      check_value("resp_valid", resp_valid, 0);
      @(negedge clock);
    end
    kill = 1'b1;
    @(negedge clock);
    kill = 1'b0;
    check_value("req_ready", req_ready, 1);
    repeat (40) begin
      check_value("resp_valid", resp_valid, 0);
      @(negedge clock);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] b;
    errors     = 0;
    checks     = 0;
    rand_state = 32'd96;
    table_done = 1'b0;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    kill       = 1'b0;
    resp_ready = 1'b0;

    // Multiplies with negative, all-ones and most negative operands
    add_row(muldiv_pkg::fn_mul, 32'hffff_fff9, 32'd6);
    add_row(muldiv_pkg::fn_mul, 32'h8000_0000, 32'h8000_0000);
    add_row(muldiv_pkg::fn_mul, 32'hffff_ffff, 32'hffff_ffff);
    add_row(muldiv_pkg::fn_mulh, 32'hffff_fff9, 32'd6);
    add_row(muldiv_pkg::fn_mulh, 32'h8000_0000, 32'h8000_0000);
    add_row(muldiv_pkg::fn_mulh, 32'h8000_0000, 32'h7fff_ffff);
    add_row(muldiv_pkg::fn_mulh, 32'h1234_5678, 32'h9abc_def0);
    add_row(muldiv_pkg::fn_mulhsu, 32'hffff_fff9, 32'd6);
    add_row(muldiv_pkg::fn_mulhsu, 32'hffff_ffff, 32'hffff_ffff);
    add_row(muldiv_pkg::fn_mulhsu, 32'h8000_0000, 32'h8000_0000);
    add_row(muldiv_pkg::fn_mulhu, 32'hffff_ffff, 32'hffff_ffff);
    add_row(muldiv_pkg::fn_mulhu, 32'h1234_5678, 32'h9abc_def0);
    add_row(muldiv_pkg::fn_mulhu, 32'h0, 32'hffff_ffff);
    // Divides over every sign pair plus zero divisor and overflow
    add_row(muldiv_pkg::fn_div, 32'd20, 32'd6);
    add_row(muldiv_pkg::fn_div, 32'hffff_ffec, 32'd6);
    add_row(muldiv_pkg::fn_div, 32'd20, 32'hffff_fffa);
    add_row(muldiv_pkg::fn_div, 32'hffff_ffec, 32'hffff_fffa);
    add_row(muldiv_pkg::fn_div, 32'd7, 32'h0);
    add_row(muldiv_pkg::fn_div, 32'h8000_0000, 32'hffff_ffff);
    add_row(muldiv_pkg::fn_divu, 32'hffff_ffec, 32'd6);
    add_row(muldiv_pkg::fn_divu, 32'd7, 32'h0);
    add_row(muldiv_pkg::fn_rem, 32'd20, 32'd6);
    add_row(muldiv_pkg::fn_rem, 32'hffff_ffec, 32'd6);
    add_row(muldiv_pkg::fn_rem, 32'd20, 32'hffff_fffa);
    add_row(muldiv_pkg::fn_rem, 32'hffff_ffec, 32'hffff_fffa);
    add_row(muldiv_pkg::fn_rem, 32'hffff_fff9, 32'h0);
    add_row(muldiv_pkg::fn_rem, 32'h8000_0000, 32'hffff_ffff);
    add_row(muldiv_pkg::fn_remu, 32'hffff_ffec, 32'd6);
    add_row(muldiv_pkg::fn_remu, 32'd7, 32'h0);

    // Random rows take only the upper LCG bits
    for (int i = 0; i < 40; i++) begin
      r1 = lcg_next();
      r2 = lcg_next();
      r3 = lcg_next();
      r4 = lcg_next();
      b  = {r3[31:16], r4[31:16]};
      if (r1[21:20] == 2'b00)
        b = b >> r1[28:24];  // Small divisors now and then
      add_row(muldiv_pkg::fn_t'({1'b0, r1[18:16]}), {r2[31:16], r1[31:16]}, b);
    end
    table_done = 1'b1;

    repeat (2) @(negedge clock);
    reset = 1'b0;
    check_value("req_ready", req_ready, 1);
    check_value("resp_valid", resp_valid, 0);
    check_value("resp", resp, 0);

    foreach (rows[i])
      run_row(rows[i]);

    kill_divide(make_row(muldiv_pkg::fn_div, 32'h8000_0001, 32'd3, 5'd30));
    run_row(make_row(muldiv_pkg::fn_rem, 32'hffff_ff9c, 32'd7, 5'd31));

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    wait (table_done);
    #((rows.size() + 2) * 40 * 4 + 2000);  // 40 cycles per row plus margin
    $display("Timeout, the test sequence did not finish in time");
    $display("checks %0d, errors %0d", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verification
hdl/muldiv_pkg.sv
hdl/muldiv_decode.sv
hdl/muldiv_mul_step.sv
hdl/muldiv_div_step.sv
hdl/muldiv_ctrl.sv
hdl/muldiv_unit.sv
verification/muldiv_tb.sv
